// File: hdl/raster_consts.svh
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Vertex coordinate width, screen space before clipping
`define RASTER_COORD_W 8

// Visible screen, pixels run 0 .. size-1
`define RASTER_SCREEN_W 64
`define RASTER_SCREEN_H 48

// Pixel coordinate width inside the screen
`define RASTER_PIX_W 6

// Flat shading attributes
`define RASTER_COLOR_W 24
`define RASTER_DEPTH_W 16

// Edge function widths
// Coefficients a and b are coordinate differences
`define RASTER_COEF_W 9
`define RASTER_EDGE_W 20

`endif

// File: hdl/geom_pkg.sv
`include "raster_consts.svh"

package geom_pkg;

    typedef struct packed {
        logic [`RASTER_COORD_W-1:0] x;
        logic [`RASTER_COORD_W-1:0] y;
    } vertex_t;

    typedef struct packed {
        vertex_t [2:0]              v;
        logic [`RASTER_COLOR_W-1:0] color;
        logic [`RASTER_DEPTH_W-1:0] depth;
    } triangle_t;

    // Clipped bounding box, empty when nothing is on screen
    typedef struct packed {
        logic [`RASTER_COORD_W-1:0] min_x;
        logic [`RASTER_COORD_W-1:0] min_y;
        logic [`RASTER_COORD_W-1:0] max_x;
        logic [`RASTER_COORD_W-1:0] max_y;
        logic                       empty;
    } bbox_t;

    // Edge value is a*x + b*y + c
    typedef struct packed {
        logic signed [`RASTER_COEF_W-1:0] a;
        logic signed [`RASTER_COEF_W-1:0] b;
        logic signed [`RASTER_EDGE_W-1:0] c;
    } edge_t;

    typedef struct packed {
        edge_t [2:0] e;
        logic        zero_area;
    } edges_t;

    // Shared by edge setup (area sign) and per-pixel coverage
    function automatic logic signed [`RASTER_EDGE_W-1:0] edge_eval(
        edge_t                      ed,
        logic [`RASTER_COORD_W-1:0] x,
        logic [`RASTER_COORD_W-1:0] y
    );
        logic signed [`RASTER_EDGE_W-1:0] sx;
        logic signed [`RASTER_EDGE_W-1:0] sy;
        sx = `RASTER_EDGE_W'(x);
        sy = `RASTER_EDGE_W'(y);
        return ed.a * sx + ed.b * sy + ed.c;
    endfunction

endpackage

// File: hdl/frag_pkg.sv
`include "raster_consts.svh"

package frag_pkg;

    typedef enum logic [0:0] {
        IDLE,
        RUN
    } trav_state_t;

    // One scanned pixel with everything needed for the coverage test
    typedef struct packed {
        logic [`RASTER_PIX_W-1:0]   x;
        logic [`RASTER_PIX_W-1:0]   y;
        geom_pkg::edges_t           edges;
        logic [`RASTER_COLOR_W-1:0] color;
        logic [`RASTER_DEPTH_W-1:0] depth;
    } pixel_state_t;

    // Covered pixel leaving the rasterizer
    typedef struct packed {
        logic [`RASTER_PIX_W-1:0]   x;
        logic [`RASTER_PIX_W-1:0]   y;
        logic [`RASTER_COLOR_W-1:0] color;
        logic [`RASTER_DEPTH_W-1:0] depth;
    } fragment_t;

endpackage

// File: hdl/bbox_setup.sv
`include "raster_consts.svh"

module bbox_setup (
    input  logic                clk,
    input  logic                rst,
    input  geom_pkg::triangle_t tri_in,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                accept,
    input  logic                setup_ready,
    output logic                setup_valid,
    output geom_pkg::bbox_t     bbox
);
    geom_pkg::bbox_t            bbox_next;
    logic [`RASTER_COORD_W-1:0] lo_x;
    logic [`RASTER_COORD_W-1:0] lo_y;
    logic [`RASTER_COORD_W-1:0] hi_x;
    logic [`RASTER_COORD_W-1:0] hi_y;

    // Stage is free when empty or handing over this cycle
    assign in_ready = !setup_valid || setup_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        lo_x = tri_in.v[0].x;
        lo_y = tri_in.v[0].y;
        hi_x = tri_in.v[0].x;
        hi_y = tri_in.v[0].y;
        for (int i = 1; i < 3; i++) begin
            if (tri_in.v[i].x < lo_x) lo_x = tri_in.v[i].x;
            if (tri_in.v[i].y < lo_y) lo_y = tri_in.v[i].y;
            if (tri_in.v[i].x > hi_x) hi_x = tri_in.v[i].x;
            if (tri_in.v[i].y > hi_y) hi_y = tri_in.v[i].y;
        end

        bbox_next.min_x = lo_x;
        bbox_next.min_y = lo_y;
        // Clamp to the last visible pixel
        bbox_next.max_x = (hi_x > `RASTER_COORD_W'(`RASTER_SCREEN_W - 1)) ?
                          `RASTER_COORD_W'(`RASTER_SCREEN_W - 1) : hi_x;
        bbox_next.max_y = (hi_y > `RASTER_COORD_W'(`RASTER_SCREEN_H - 1)) ?
                          `RASTER_COORD_W'(`RASTER_SCREEN_H - 1) : hi_y;
        bbox_next.empty = (lo_x >= `RASTER_COORD_W'(`RASTER_SCREEN_W)) ||
                          (lo_y >= `RASTER_COORD_W'(`RASTER_SCREEN_H));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            setup_valid <= 1'b0;
        end else if (in_ready) begin
            setup_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bbox <= bbox_next;
        end
    end

    // A held triangle waits for traversal
    a_setup_hold: assert property (@(posedge clk) disable iff (rst)
        setup_valid && !setup_ready |=> setup_valid);

endmodule

// File: hdl/edge_setup.sv
`include "raster_consts.svh"

module edge_setup (
    input  logic                       clk,
    input  logic                       rst,
    input  geom_pkg::triangle_t        tri_in,
    input  logic                       accept,
    output geom_pkg::edges_t           edges,
    output logic [`RASTER_COLOR_W-1:0] color,
    output logic [`RASTER_DEPTH_W-1:0] depth
);
    geom_pkg::edges_t                 edges_next;
    logic signed [`RASTER_EDGE_W-1:0] area;

    always_comb begin
        geom_pkg::vertex_t vi;
        geom_pkg::vertex_t vn;
        // Edge i runs from vertex i to vertex i+1
        for (int i = 0; i < 3; i++) begin
            vi = tri_in.v[i];
            vn = tri_in.v[(i + 1) % 3];
            edges_next.e[i].a = $signed({1'b0, vi.y}) - $signed({1'b0, vn.y});
            edges_next.e[i].b = $signed({1'b0, vn.x}) - $signed({1'b0, vi.x});
            edges_next.e[i].c = `RASTER_EDGE_W'(vi.x * vn.y) -
                                `RASTER_EDGE_W'(vn.x * vi.y);
        end
        // Twice the signed area, from edge 0 at the opposite vertex
        area = geom_pkg::edge_eval(edges_next.e[0], tri_in.v[2].x, tri_in.v[2].y);
        edges_next.zero_area = (area == '0);
    end

    // Loads share the accept of bbox_setup, which tracks validity
    always_ff @(posedge clk) begin
        if (accept) begin
            edges <= edges_next;
            color <= tri_in.color;
            depth <= tri_in.depth;
        end
    end

endmodule

// File: hdl/pixel_traversal.sv
`include "raster_consts.svh"

module pixel_traversal (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       setup_valid,
    output logic                       setup_ready,
    input  geom_pkg::bbox_t            bbox,
    input  geom_pkg::edges_t           edges,
    input  logic [`RASTER_COLOR_W-1:0] color,
    input  logic [`RASTER_DEPTH_W-1:0] depth,
    output frag_pkg::pixel_state_t     pix_out,
    output logic                       pix_valid,
    input  logic                       pix_ready,
    output logic                       busy
);
    frag_pkg::trav_state_t state;
    frag_pkg::trav_state_t next_state;

    // Triangle latched for the duration of the scan
    geom_pkg::bbox_t            box_r;
    geom_pkg::edges_t           edges_r;
    logic [`RASTER_COLOR_W-1:0] color_r;
    logic [`RASTER_DEPTH_W-1:0] depth_r;

    logic [`RASTER_PIX_W-1:0] cur_x;
    logic [`RASTER_PIX_W-1:0] cur_y;
    logic [`RASTER_PIX_W-1:0] next_x;
    logic [`RASTER_PIX_W-1:0] next_y;

    logic take;
    logic can_emit;

    assign take        = setup_valid && setup_ready;
    assign setup_ready = (state == frag_pkg::IDLE);
    // Buffer free now or drained this cycle
    assign can_emit    = !pix_valid || pix_ready;
    assign busy        = (state == frag_pkg::RUN) || pix_valid;

    always_comb begin
        next_state = state;
        next_x     = cur_x;
        next_y     = cur_y;
        case (state)
            frag_pkg::IDLE: begin
                // An empty box is consumed without a scan
                if (take && !bbox.empty) begin
                    next_state = frag_pkg::RUN;
                    next_x     = bbox.min_x[`RASTER_PIX_W-1:0];
                    next_y     = bbox.min_y[`RASTER_PIX_W-1:0];
                end
            end
            frag_pkg::RUN: begin
                if (can_emit) begin
                    if (cur_x < box_r.max_x) begin
                        next_x = cur_x + `RASTER_PIX_W'(1);
                    end else begin
                        next_x = box_r.min_x[`RASTER_PIX_W-1:0];
                        if (cur_y < box_r.max_y) begin
                            next_y = cur_y + `RASTER_PIX_W'(1);
                        end else begin
                            next_state = frag_pkg::IDLE;  // last pixel of the box
                        end
                    end
                end
            end
            default: next_state = frag_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= frag_pkg::IDLE;
            cur_x     <= '0;
            cur_y     <= '0;
            pix_valid <= 1'b0;
        end else begin
            state <= next_state;
            cur_x <= next_x;
            cur_y <= next_y;
            if (state == frag_pkg::RUN && can_emit) begin
                pix_valid <= 1'b1;
            end else if (pix_ready) begin
                pix_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            box_r   <= bbox;
            edges_r <= edges;
            color_r <= color;
            depth_r <= depth;
        end
        if (state == frag_pkg::RUN && can_emit) begin
            pix_out.x     <= cur_x;
            pix_out.y     <= cur_y;
            pix_out.edges <= edges_r;
            pix_out.color <= color_r;
            pix_out.depth <= depth_r;
        end
    end

    // Scan never leaves the latched box
    a_in_box: assert property (@(posedge clk) disable iff (rst)
        state == frag_pkg::RUN |->
            cur_x >= box_r.min_x && cur_x <= box_r.max_x &&
            cur_y >= box_r.min_y && cur_y <= box_r.max_y);

    // Setup is held off during a scan
    a_run_blocks: assert property (@(posedge clk) disable iff (rst)
        state == frag_pkg::RUN |-> !setup_ready);

endmodule

// File: hdl/fragment_eval.sv
`include "raster_consts.svh"

module fragment_eval (
    input  logic                   clk,
    input  logic                   rst,
    input  frag_pkg::pixel_state_t pix_in,
    input  logic                   pix_valid,
    output logic                   pix_ready,
    output frag_pkg::fragment_t    frag_out,
    output logic                   out_valid,
    input  logic                   out_ready
);
    logic signed [`RASTER_EDGE_W-1:0] ev [3];
    logic all_pos;
    logic all_neg;
    logic covered;

    // Either winding passes, pixels on an edge count
    always_comb begin
        all_pos = 1'b1;
        all_neg = 1'b1;
        for (int i = 0; i < 3; i++) begin
            ev[i] = geom_pkg::edge_eval(pix_in.edges.e[i],
                                        `RASTER_COORD_W'(pix_in.x),
                                        `RASTER_COORD_W'(pix_in.y));
            if (ev[i] < 0) all_pos = 1'b0;
            if (ev[i] > 0) all_neg = 1'b0;
        end
        covered = !pix_in.edges.zero_area && (all_pos || all_neg);
    end

    assign pix_ready = !out_valid || out_ready;

    // Uncovered pixels are consumed here and go nowhere
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (pix_valid && pix_ready && covered) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid && pix_ready && covered) begin
            frag_out.x     <= pix_in.x;
            frag_out.y     <= pix_in.y;
            frag_out.color <= pix_in.color;
            frag_out.depth <= pix_in.depth;
        end
    end

    // Stalled output holds its fragment
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(frag_out));

endmodule

// File: hdl/raster_top.sv
`include "raster_consts.svh"

module raster_top (
    input  logic                clk,
    input  logic                rst,
    input  geom_pkg::triangle_t tri_in,
    input  logic                in_valid,
    output logic                in_ready,
    output frag_pkg::fragment_t frag_out,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                busy
);
    logic                       accept;
    logic                       setup_valid;
    logic                       setup_ready;
    geom_pkg::bbox_t            bbox;
    geom_pkg::edges_t           edges;
    logic [`RASTER_COLOR_W-1:0] color;
    logic [`RASTER_DEPTH_W-1:0] depth;
    frag_pkg::pixel_state_t     pix;
    logic                       pix_valid;
    logic                       pix_ready;
    logic                       trav_busy;

    // Both setup halves see the same triangle and load together
    bbox_setup u_bbox (
        .clk, .rst, .tri_in, .in_valid, .in_ready, .accept,
        .setup_ready, .setup_valid, .bbox
    );

    edge_setup u_edge (
        .clk, .rst, .tri_in, .accept, .edges, .color, .depth
    );

    pixel_traversal u_trav (
        .clk, .rst, .setup_valid, .setup_ready, .bbox, .edges, .color, .depth,
        .pix_out (pix),
        .pix_valid,
        .pix_ready,
        .busy    (trav_busy)
    );

    fragment_eval u_eval (
        .clk, .rst,
        .pix_in  (pix),
        .pix_valid, .pix_ready, .frag_out, .out_valid, .out_ready
    );

    // Traversal already covers its own pixel buffer
    assign busy = setup_valid || trav_busy || out_valid;

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops shortly after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// File: tb/raster_model.svh
`ifndef RASTER_MODEL_SVH
`define RASTER_MODEL_SVH

// Edge i runs from vertex i to vertex i+1 with value a*x + b*y + c
function automatic int edge_value(input geom_pkg::triangle_t t, input int i,
                                  input int px, input int py);
    int xi;
    int yi;
    int xn;
    int yn;
    xi = t.v[i].x;
    yi = t.v[i].y;
    xn = t.v[(i + 1) % 3].x;
    yn = t.v[(i + 1) % 3].y;
    return (yi - yn) * px + (xn - xi) * py + (xi * yn - xn * yi);
endfunction

// Vertex bounds with max clamped to the last visible pixel
function automatic void clip_box(input geom_pkg::triangle_t t, output int x0, output int y0,
                                 output int x1, output int y1, output logic empty);
    x0 = t.v[0].x;
    y0 = t.v[0].y;
    x1 = x0;
    y1 = y0;
    for (int i = 1; i < 3; i++) begin
        x0 = (t.v[i].x < x0) ? int'(t.v[i].x) : x0;
        y0 = (t.v[i].y < y0) ? int'(t.v[i].y) : y0;
        x1 = (t.v[i].x > x1) ? int'(t.v[i].x) : x1;
        y1 = (t.v[i].y > y1) ? int'(t.v[i].y) : y1;
    end
    x1 = (x1 > `RASTER_SCREEN_W - 1) ? `RASTER_SCREEN_W - 1 : x1;
    y1 = (y1 > `RASTER_SCREEN_H - 1) ? `RASTER_SCREEN_H - 1 : y1;
    empty = (x0 >= `RASTER_SCREEN_W) || (y0 >= `RASTER_SCREEN_H);
endfunction

// Queues the covered pixels of one triangle in raster order
function automatic void append_expected(input geom_pkg::triangle_t t);
    int x0;
    int y0;
    int x1;
    int y1;
    logic empty;
    int e0;
    int e1;
    int e2;
    frag_pkg::fragment_t f;
    clip_box(t, x0, y0, x1, y1, empty);
    if (empty || edge_value(t, 0, t.v[2].x, t.v[2].y) == 0) return;
    for (int y = y0; y <= y1; y++) begin
        for (int x = x0; x <= x1; x++) begin
            e0 = edge_value(t, 0, x, y);
            e1 = edge_value(t, 1, x, y);
            e2 = edge_value(t, 2, x, y);
            if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
                f.x     = `RASTER_PIX_W'(x);
                f.y     = `RASTER_PIX_W'(y);
                f.color = t.color;
                f.depth = t.depth;
                expected_q.push_back(f);
            end
        end
    end
endfunction

`endif

// File: tb/tb_raster.sv
`include "raster_consts.svh"

module tb_raster;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS          = 40;
    localparam int DRIVE_NS        = 2;
    localparam int N_BASIC         = 4;
    localparam int N_STREAM        = 12;
    localparam int N_STALL         = 10;
    localparam int N_CLIP          = 12;
    localparam int N_DEGEN         = 12;
    localparam int N_TRIS          = N_BASIC + N_STREAM + N_STALL + N_CLIP + N_DEGEN;
    // Cycles allowed for one full-screen box
    localparam int SCAN_BUDGET     = `RASTER_SCREEN_W * `RASTER_SCREEN_H * 4;
    localparam int DRAIN_LIMIT     = 4 * SCAN_BUDGET;
    localparam int OFFSCREEN_LIMIT = 4;
    localparam logic [31:0] SEED   = 32'h01e4bf24;

    logic                clk;
    logic                rst;
    geom_pkg::triangle_t tri_in;
    logic                in_valid;
    logic                in_ready;
    frag_pkg::fragment_t frag_out;
    logic                out_valid;
    logic                out_ready;
    logic                busy;

    frag_pkg::fragment_t expected_q[$];
    logic [31:0]         rng;
    logic [31:0]         bp_rng;
    int                  ready_pct;
    string               test_name;
    int                  test_errors;
    int                  tests_passed;
    int                  tests_failed;
    logic                stalled;
    frag_pkg::fragment_t stalled_frag;

    `include "raster_model.svh"

    tb_clock u_clock (.clk(clk), .rst(rst));

    raster_top dut (
        .clk, .rst, .tri_in, .in_valid, .in_ready,
        .frag_out, .out_valid, .out_ready, .busy
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng = xorshift32(rng);
        return lo + int'(rng % (hi - lo + 1));
    endfunction

    function automatic geom_pkg::triangle_t make_triangle(input int x_lo, input int x_hi,
                                                         input int y_lo, input int y_hi);
        geom_pkg::triangle_t t;
        for (int i = 0; i < 3; i++) begin
            t.v[i].x = `RASTER_COORD_W'(rand_range(x_lo, x_hi));
            t.v[i].y = `RASTER_COORD_W'(rand_range(y_lo, y_hi));
        end
        t.color = `RASTER_COLOR_W'(rand_range(0, 24'hffffff));
        t.depth = `RASTER_DEPTH_W'(rand_range(0, 16'hffff));
        return t;
    endfunction

    function automatic string fmt_frag(input frag_pkg::fragment_t f);
        return $sformatf("x=%0d y=%0d color=%h depth=%h", f.x, f.y, f.color, f.depth);
    endfunction

    // Back-pressure on the output side
    always @(posedge clk) begin
        #DRIVE_NS;
        if (ready_pct >= 100) begin
            out_ready = 1'b1;
        end else begin
            bp_rng = xorshift32(bp_rng);
            out_ready = (bp_rng % 100) < ready_pct;
        end
    end

    // Output scoreboard, sampled mid-cycle
    always @(negedge clk) begin : monitor
        frag_pkg::fragment_t want;
        if (rst === 1'b0) begin
            if (stalled) begin
                assert (out_valid === 1'b1 && frag_out === stalled_frag) else begin
                    $display("ERROR %s: stalled output changed or dropped valid", test_name);
                    test_errors++;
                end
            end
            stalled      = out_valid && !out_ready;
            stalled_frag = frag_out;
            if (out_valid && out_ready) begin
                assert (expected_q.size() > 0) else begin
                    $display("ERROR %s: unexpected extra fragment %s", test_name,
                             fmt_frag(frag_out));
                    test_errors++;
                end
                if (expected_q.size() > 0) begin
                    want = expected_q.pop_front();
                    assert (frag_out === want) else begin
                        $display("MISMATCH %s: expected %s, actual %s", test_name,
                                 fmt_frag(want), fmt_frag(frag_out));
                        test_errors++;
                    end
                end
            end
        end
    end

    task automatic next_slot();
        @(posedge clk);
        #DRIVE_NS;
    endtask

    // Entered and left at the drive slot after a rising edge
    task automatic send_triangle(input geom_pkg::triangle_t t);
        tri_in   = t;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        append_expected(t);
        next_slot();
        in_valid = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (!busy) else begin
            $display("ERROR %s: design still busy after %0d cycles", test_name, limit);
            test_errors++;
        end
        assert (expected_q.size() == 0) else begin
            $display("ERROR %s: %0d expected fragments never arrived", test_name,
                     expected_q.size());
            test_errors++;
            expected_q.delete();
        end
        next_slot();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %-8s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic run_basic();
        start_test("basic");
        @(negedge clk);
        assert (out_valid === 1'b0 && busy === 1'b0 && in_ready === 1'b1) else begin
            $display("ERROR %s: wrong idle state after reset, out_valid=%b busy=%b in_ready=%b",
                     test_name, out_valid, busy, in_ready);
            test_errors++;
        end
        next_slot();
        for (int i = 0; i < N_BASIC; i++) begin
            send_triangle(make_triangle(4, 59, 4, 43));
            wait_idle(DRAIN_LIMIT);
        end
        finish_test();
    endtask

    task automatic run_stream();
        start_test("stream");
        for (int i = 0; i < N_STREAM; i++) begin
            send_triangle(make_triangle(0, `RASTER_SCREEN_W - 1, 0, `RASTER_SCREEN_H - 1));
        end
        wait_idle(DRAIN_LIMIT);
        finish_test();
    endtask

    task automatic run_stall();
        start_test("stall");
        for (int i = 0; i < N_STALL; i++) begin
            ready_pct = rand_range(40, 90);
            send_triangle(make_triangle(0, `RASTER_SCREEN_W - 1, 0, `RASTER_SCREEN_H - 1));
        end
        wait_idle(DRAIN_LIMIT);
        ready_pct = 100;
        finish_test();
    endtask

    task automatic run_clip();
        geom_pkg::triangle_t t;
        start_test("clip");
        for (int i = 0; i < N_CLIP; i++) begin
            if (i % 4 == 3) begin
                // Fully off screen, right side or below
                wait_idle(DRAIN_LIMIT);
                if (i % 8 == 3) begin
                    t = make_triangle(`RASTER_SCREEN_W, 255, 0, 255);
                end else begin
                    t = make_triangle(0, 255, `RASTER_SCREEN_H, 255);
                end
                send_triangle(t);
                wait_idle(OFFSCREEN_LIMIT);
            end else begin
                send_triangle(make_triangle(0, 120, 0, 90));
            end
        end
        wait_idle(DRAIN_LIMIT);
        finish_test();
    endtask

    task automatic run_degen();
        geom_pkg::triangle_t t;
        int dx;
        int dy;
        int k;
        start_test("degen");
        for (int i = 0; i < N_DEGEN; i++) begin
            t = make_triangle(0, `RASTER_SCREEN_W - 1, 0, `RASTER_SCREEN_H - 1);
            case (rand_range(0, 2))
                1: begin
                    k = rand_range(1, 2);
                    t.v[k] = t.v[0];
                end
                2: begin
                    // Three points on one line through vertex 0
                    dx = rand_range(-10, 10);
                    dy = rand_range(-10, 10);
                    t.v[0].x = `RASTER_COORD_W'(rand_range(20, 43));
                    t.v[0].y = `RASTER_COORD_W'(rand_range(20, 27));
                    t.v[1].x = `RASTER_COORD_W'(int'(t.v[0].x) + dx);
                    t.v[1].y = `RASTER_COORD_W'(int'(t.v[0].y) + dy);
                    t.v[2].x = `RASTER_COORD_W'(int'(t.v[0].x) - 2 * dx);
                    t.v[2].y = `RASTER_COORD_W'(int'(t.v[0].y) - 2 * dy);
                end
                default: ;
            endcase
            send_triangle(t);
        end
        wait_idle(DRAIN_LIMIT);
        finish_test();
    endtask

    initial begin
        tri_in       = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        ready_pct    = 100;
        rng          = SEED;
        bp_rng       = ~SEED;
        test_name    = "reset";
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        stalled      = 1'b0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        run_basic();
        run_stream();
        run_stall();
        run_clip();
        run_degen();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_TRIS * SCAN_BUDGET + 1000) * CLK_NS);
        $display("ERROR watchdog expired in test %s, the run did not finish", test_name);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
+incdir+tb
hdl/geom_pkg.sv
hdl/frag_pkg.sv
hdl/bbox_setup.sv
hdl/edge_setup.sv
hdl/pixel_traversal.sv
hdl/fragment_eval.sv
hdl/raster_top.sv
tb/tb_clock.sv
tb/tb_raster.sv

// File: Bender.yml
package:
  name: raster

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/geom_pkg.sv
      - hdl/frag_pkg.sv
      - hdl/bbox_setup.sv
      - hdl/edge_setup.sv
      - hdl/pixel_traversal.sv
      - hdl/fragment_eval.sv
      - hdl/raster_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - tb
    files:
      - tb/tb_clock.sv
      - tb/tb_raster.sv
